// File: logic/mipsPkg.sv
package mipsPkg;

    // opcodes
    localparam logic [5:0] OP_RTYPE = 6'b000000;
    localparam logic [5:0] OP_J     = 6'b000010;
    localparam logic [5:0] OP_BEQ   = 6'b000100;
    localparam logic [5:0] OP_BNE   = 6'b000101;
    localparam logic [5:0] OP_BLEZ  = 6'b000110;
    localparam logic [5:0] OP_BGTZ  = 6'b000111;
    localparam logic [5:0] OP_ADDI  = 6'b001000;
    localparam logic [5:0] OP_ADDIU = 6'b001001;
    localparam logic [5:0] OP_ANDI  = 6'b001100;
    localparam logic [5:0] OP_ORI   = 6'b001101;
    localparam logic [5:0] OP_XORI  = 6'b001110;
    localparam logic [5:0] OP_LW    = 6'b100011;
    localparam logic [5:0] OP_SW    = 6'b101011;

    // function field of register instructions
    localparam logic [5:0] FN_SLLV = 6'b000100;
    localparam logic [5:0] FN_SRLV = 6'b000110;
    localparam logic [5:0] FN_SRAV = 6'b000111;
    localparam logic [5:0] FN_JR   = 6'b001000;
    localparam logic [5:0] FN_ADD  = 6'b100000;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUB  = 6'b100010;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_NOR  = 6'b100111;

    localparam logic [2:0] ALU_AND = 3'b000;
    localparam logic [2:0] ALU_OR  = 3'b001;
    localparam logic [2:0] ALU_ADD = 3'b010;
    localparam logic [2:0] ALU_XOR = 3'b101;
    localparam logic [2:0] ALU_NOR = 3'b100;
    localparam logic [2:0] ALU_SUB = 3'b110;

    localparam logic [1:0] SH_SLL = 2'b10;
    localparam logic [1:0] SH_SRL = 2'b00;
    localparam logic [1:0] SH_SRA = 2'b01;

    localparam logic [2:0] CMP_EQ  = 3'b000;
    localparam logic [2:0] CMP_NE  = 3'b101;
    localparam logic [2:0] CMP_LEZ = 3'b010;
    localparam logic [2:0] CMP_GTZ = 3'b011;

    localparam logic [1:0] PC_NEXT = 2'b00;
    localparam logic [1:0] PC_REG  = 2'b01;
    localparam logic [1:0] PC_JUMP = 2'b10;

    localparam logic [1:0] BR_NONE   = 2'b00;
    localparam logic [1:0] BR_BRANCH = 2'b10;
    localparam logic [1:0] BR_JUMP   = 2'b01;

    localparam logic [31:0] RESET_PC = 32'h0000_0000;

    // instruction layouts
    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] fn;
    } regLayout;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } immLayout;

    typedef struct packed {
        logic [5:0]  op;
        logic [25:0] target;
    } jumpLayout;

    typedef union packed {
        regLayout  r;
        immLayout  i;
        jumpLayout j;
    } instrWord;

endpackage

// File: logic/control.sv
`timescale 1ns/1ps

module control import mipsPkg::*; (
    input  logic [5:0] op,
    input  logic [5:0] fn,
    output logic       selWSource,
    output logic       selRegDest,
    output logic       writeReg,
    output logic       writeOv,
    output logic       selImRegB,
    output logic       selAluShift,
    output logic [2:0] aluOp,
    output logic [1:0] shiftOp,
    output logic       readMem,
    output logic       writeMem,
    output logic [1:0] selBrJumpZ,
    output logic [1:0] selPcType,
    output logic [2:0] compOp,
    output logic       unsig
);

    logic [20:0] ctrl;

    assign selImRegB   = ctrl[20];
    assign selBrJumpZ  = ctrl[19:18];
    assign selRegDest  = ctrl[17];
    assign selWSource  = ctrl[16];
    assign writeReg    = ctrl[15];
    assign writeOv     = ctrl[14];
    assign unsig       = ctrl[13];
    assign shiftOp     = ctrl[12:11];
    assign aluOp       = ctrl[10:8];
    assign selAluShift = ctrl[7];
    assign compOp      = ctrl[6:4];
    assign selPcType   = ctrl[3:2];
    assign readMem     = ctrl[1];
    assign writeMem    = ctrl[0];

    // row layout: imB, brJump, {regDest wSrc wReg wOv unsig}, shift, alu,
    // aluShift, compare, pcType, {readMem writeMem}
    always_comb begin
        casez ({op, fn})
            {OP_RTYPE, FN_SLLV}:
                ctrl = {1'b0, BR_NONE, 5'b10110, SH_SLL, 3'd0, 1'b1, 3'd0, PC_NEXT, 2'b00};
            {OP_RTYPE, FN_SRLV}:
                ctrl = {1'b0, BR_NONE, 5'b10110, SH_SRL, 3'd0, 1'b1, 3'd0, PC_NEXT, 2'b00};
            {OP_RTYPE, FN_SRAV}:
                ctrl = {1'b0, BR_NONE, 5'b10110, SH_SRA, 3'd0, 1'b1, 3'd0, PC_NEXT, 2'b00};
            {OP_RTYPE, FN_JR}:
                ctrl = {1'b0, BR_JUMP, 5'b00000, 2'd0, 3'd0, 1'b0, 3'd0, PC_REG, 2'b00};
            // signed forms leave wOv low so overflow blocks the write
            {OP_RTYPE, FN_ADD}:
                ctrl = {1'b0, BR_NONE, 5'b10100, 2'd0, ALU_ADD, 1'b0, 3'd0, PC_NEXT, 2'b00};
            {OP_RTYPE, FN_ADDU}:
                ctrl = {1'b0, BR_NONE, 5'b10111, 2'd0, ALU_ADD, 1'b0, 3'd0, PC_NEXT, 2'b00};
            {OP_RTYPE, FN_SUB}:
                ctrl = {1'b0, BR_NONE, 5'b10100, 2'd0, ALU_SUB, 1'b0, 3'd0, PC_NEXT, 2'b00};
            {OP_RTYPE, FN_SUBU}:
                ctrl = {1'b0, BR_NONE, 5'b10111, 2'd0, ALU_SUB, 1'b0, 3'd0, PC_NEXT, 2'b00};
            {OP_RTYPE, FN_AND}:
                ctrl = {1'b0, BR_NONE, 5'b10110, 2'd0, ALU_AND, 1'b0, 3'd0, PC_NEXT, 2'b00};
            {OP_RTYPE, FN_OR}:
                ctrl = {1'b0, BR_NONE, 5'b10110, 2'd0, ALU_OR, 1'b0, 3'd0, PC_NEXT, 2'b00};
            {OP_RTYPE, FN_XOR}:
                ctrl = {1'b0, BR_NONE, 5'b10110, 2'd0, ALU_XOR, 1'b0, 3'd0, PC_NEXT, 2'b00};
            {OP_RTYPE, FN_NOR}:
                ctrl = {1'b0, BR_NONE, 5'b10110, 2'd0, ALU_NOR, 1'b0, 3'd0, PC_NEXT, 2'b00};
            {OP_J, 6'b??????}:
                ctrl = {1'b0, BR_JUMP, 5'b00000, 2'd0, 3'd0, 1'b0, 3'd0, PC_JUMP, 2'b00};
            {OP_BEQ, 6'b??????}:
                ctrl = {1'b0, BR_BRANCH, 5'b00000, 2'd0, 3'd0, 1'b0, CMP_EQ, PC_NEXT, 2'b00};
            {OP_BNE, 6'b??????}:
                ctrl = {1'b0, BR_BRANCH, 5'b00000, 2'd0, 3'd0, 1'b0, CMP_NE, PC_NEXT, 2'b00};
            {OP_BLEZ, 6'b??????}:
                ctrl = {1'b0, BR_BRANCH, 5'b00000, 2'd0, 3'd0, 1'b0, CMP_LEZ, PC_NEXT, 2'b00};
            {OP_BGTZ, 6'b??????}:
                ctrl = {1'b0, BR_BRANCH, 5'b00000, 2'd0, 3'd0, 1'b0, CMP_GTZ, PC_NEXT, 2'b00};
            {OP_ADDI, 6'b??????}:
                ctrl = {1'b1, BR_NONE, 5'b00100, 2'd0, ALU_ADD, 1'b0, 3'd0, PC_NEXT, 2'b00};
            {OP_ADDIU, 6'b??????}:
                ctrl = {1'b1, BR_NONE, 5'b00111, 2'd0, ALU_ADD, 1'b0, 3'd0, PC_NEXT, 2'b00};
            // logic immediates set unsig, which selects zero extension
            {OP_ANDI, 6'b??????}:
                ctrl = {1'b1, BR_NONE, 5'b00111, 2'd0, ALU_AND, 1'b0, 3'd0, PC_NEXT, 2'b00};
            {OP_ORI, 6'b??????}:
                ctrl = {1'b1, BR_NONE, 5'b00111, 2'd0, ALU_OR, 1'b0, 3'd0, PC_NEXT, 2'b00};
            {OP_XORI, 6'b??????}:
                ctrl = {1'b1, BR_NONE, 5'b00111, 2'd0, ALU_XOR, 1'b0, 3'd0, PC_NEXT, 2'b00};
            {OP_LW, 6'b??????}:
                ctrl = {1'b1, BR_NONE, 5'b01110, 2'd0, ALU_ADD, 1'b0, 3'd0, PC_NEXT, 2'b10};
            {OP_SW, 6'b??????}:
                ctrl = {1'b1, BR_NONE, 5'b00000, 2'd0, ALU_ADD, 1'b0, 3'd0, PC_NEXT, 2'b01};
            default:
                ctrl = '0;
        endcase
    end

endmodule

// File: logic/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  rdAddrA,
    input  logic [4:0]  rdAddrB,
    input  logic [4:0]  wrAddr,
    input  logic [31:0] wrData,
    input  logic        we,
    output logic [31:0] rdDataA,
    output logic [31:0] rdDataB
);

    // register zero has no storage
    logic [31:0] regs [31:1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wrAddr != 5'd0) begin
            regs[wrAddr] <= wrData;
        end
    end

    // reads see the value before this cycle's write
    always_comb begin
        if (rdAddrA == 5'd0) begin
            rdDataA = '0;
        end else begin
            rdDataA = regs[rdAddrA];
        end
    end

    always_comb begin
        if (rdAddrB == 5'd0) begin
            rdDataB = '0;
        end else begin
            rdDataB = regs[rdAddrB];
        end
    end

endmodule

// File: logic/alu.sv
`timescale 1ns/1ps

module alu import mipsPkg::*; (
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  logic [4:0]  shamtSrc,
    input  logic [2:0]  aluOp,
    input  logic [1:0]  shiftOp,
    input  logic        selAluShift,
    input  logic        unsig,
    output logic [31:0] result,
    output logic        overflow
);

    logic        isSub;
    logic        isArith;
    logic [31:0] bOperand;
    logic [31:0] sum;
    logic [31:0] logicResult;
    logic [31:0] shiftResult;
    logic        signedOv;

    assign isSub    = (aluOp == ALU_SUB);
    assign isArith  = (aluOp == ALU_ADD) || isSub;

    // subtract as a plus inverted b plus one
    assign bOperand = isSub ? ~b : b;
    assign sum      = a + bOperand + {31'd0, isSub};

    // same operand signs but a different result sign
    assign signedOv = (a[31] == bOperand[31]) && (sum[31] != a[31]);

    always_comb begin
        case (aluOp)
            ALU_AND: logicResult = a & b;
            ALU_OR:  logicResult = a | b;
            ALU_XOR: logicResult = a ^ b;
            ALU_NOR: logicResult = ~(a | b);
            ALU_ADD: logicResult = sum;
            ALU_SUB: logicResult = sum;
            default: logicResult = '0;
        endcase
    end

    always_comb begin
        case (shiftOp)
            SH_SLL:  shiftResult = b << shamtSrc;
            SH_SRL:  shiftResult = b >> shamtSrc;
            SH_SRA:  shiftResult = $signed(b) >>> shamtSrc;
            default: shiftResult = '0;
        endcase
    end

    assign result   = selAluShift ? shiftResult : logicResult;
    assign overflow = signedOv && isArith && !selAluShift && !unsig;

endmodule

// File: logic/branchCompare.sv
`timescale 1ns/1ps

module branchCompare import mipsPkg::*; (
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  logic [2:0]  compOp,
    output logic        taken
);

    logic isZero;
    logic isNeg;

    assign isZero = (a == 32'd0);
    assign isNeg  = a[31];

    // b only matters for the equality tests
    always_comb begin
        case (compOp)
            CMP_EQ:  taken = (a == b);
            CMP_NE:  taken = (a != b);
            CMP_LEZ: taken = isNeg || isZero;
            CMP_GTZ: taken = !isNeg && !isZero;
            default: taken = 1'b0;
        endcase
    end

endmodule

// File: logic/cpuCore.sv
`timescale 1ns/1ps

module cpuCore import mipsPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] instr,
    input  logic [31:0] dataRdData,
    output logic [31:0] instrAddr,
    output logic [31:0] dataAddr,
    output logic [31:0] dataWrData,
    output logic        dataWe,
    output logic        dataRe
);

    logic [31:0] pc;
    logic [31:0] pcNext;
    logic [31:0] pcPlus4;
    logic [31:0] branchTarget;
    logic [31:0] jumpTarget;
    instrWord    ir;

    logic        selWSource;
    logic        selRegDest;
    logic        writeReg;
    logic        writeOv;
    logic        selImRegB;
    logic        selAluShift;
    logic [2:0]  aluOp;
    logic [1:0]  shiftOp;
    logic        readMem;
    logic        writeMem;
    logic [1:0]  selBrJumpZ;
    logic [1:0]  selPcType;
    logic [2:0]  compOp;
    logic        unsig;

    logic [4:0]  wrAddr;
    logic [31:0] wrData;
    logic        regWe;
    logic [31:0] rdDataA;
    logic [31:0] rdDataB;
    logic [31:0] immExt;
    logic        zeroExt;
    logic [31:0] aluB;
    logic [31:0] aluResult;
    logic        overflow;
    logic        taken;

    assign ir = instr;

    control control_i (
        .op(ir.r.op),
        .fn(ir.r.fn),
        .selWSource(selWSource),
        .selRegDest(selRegDest),
        .writeReg(writeReg),
        .writeOv(writeOv),
        .selImRegB(selImRegB),
        .selAluShift(selAluShift),
        .aluOp(aluOp),
        .shiftOp(shiftOp),
        .readMem(readMem),
        .writeMem(writeMem),
        .selBrJumpZ(selBrJumpZ),
        .selPcType(selPcType),
        .compOp(compOp),
        .unsig(unsig)
    );

    assign wrAddr = selRegDest ? ir.r.rd : ir.r.rt;
    assign wrData = selWSource ? dataRdData : aluResult;
    assign regWe  = writeReg && (writeOv || !overflow);

    regFile regFile_i (
        .clk(clk),
        .rst(rst),
        .rdAddrA(ir.r.rs),
        .rdAddrB(ir.r.rt),
        .wrAddr(wrAddr),
        .wrData(wrData),
        .we(regWe),
        .rdDataA(rdDataA),
        .rdDataB(rdDataB)
    );

    // addiu is unsigned only for overflow and still sign-extends
    assign zeroExt = unsig && (aluOp != ALU_ADD);
    assign immExt  = zeroExt ? {16'd0, ir.i.imm} : {{16{ir.i.imm[15]}}, ir.i.imm};
    assign aluB    = selImRegB ? immExt : rdDataB;

    alu alu_i (
        .a(rdDataA),
        .b(aluB),
        .shamtSrc(rdDataA[4:0]),
        .aluOp(aluOp),
        .shiftOp(shiftOp),
        .selAluShift(selAluShift),
        .unsig(unsig),
        .result(aluResult),
        .overflow(overflow)
    );

    branchCompare branchCompare_i (
        .a(rdDataA),
        .b(rdDataB),
        .compOp(compOp),
        .taken(taken)
    );

    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pcPlus4 + {immExt[29:0], 2'b00};
    assign jumpTarget   = {pcPlus4[31:28], ir.j.target, 2'b00};

    always_comb begin
        pcNext = pcPlus4;
        if (selBrJumpZ == BR_BRANCH && taken) begin
            pcNext = branchTarget;
        end else if (selBrJumpZ == BR_JUMP) begin
            case (selPcType)
                PC_REG:  pcNext = rdDataA;
                PC_JUMP: pcNext = jumpTarget;
                default: pcNext = pcPlus4;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else begin
            pc <= pcNext;
        end
    end

    assign instrAddr  = pc;
    assign dataAddr   = aluResult;
    assign dataWrData = rdDataB;
    assign dataWe     = writeMem;
    assign dataRe     = readMem;

endmodule

// File: verif/cpuCoreTb.sv
`timescale 1ns/1ps

module cpuCoreTb import mipsPkg::*; ();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 2;
    localparam int RUN_CYCLES   = 56;
    localparam int NUM_TESTS    = 6;
    // startTest spends one extra edge before reset
    localparam int WATCHDOG_NS  = 2 * NUM_TESTS * (RUN_CYCLES + RESET_CYCLES + 1) * CLK_PERIOD;

    logic        clk;
    logic        rst;
    logic [31:0] instr;
    logic [31:0] dataRdData;
    logic [31:0] instrAddr;
    logic [31:0] dataAddr;
    logic [31:0] dataWrData;
    logic        dataWe;
    logic        dataRe;

    logic [31:0] imem [0:255];
    logic [31:0] dmem [0:255];
    logic [31:0] dataImage [0:255];
    logic [31:0] expMem [0:255];
    logic [31:0] prog [$];
    logic [31:0] endPc;
    int          swCount;
    int          weCount;
    int          lwCount;
    int          reCount;
    int          errors;
    int          errStart;
    int          testsRun;
    int          testsFailed;

    cpuCore cpuCore_i (
        .clk(clk),
        .rst(rst),
        .instr(instr),
        .dataRdData(dataRdData),
        .instrAddr(instrAddr),
        .dataAddr(dataAddr),
        .dataWrData(dataWrData),
        .dataWe(dataWe),
        .dataRe(dataRe)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // memories answer in the same cycle
    assign instr      = imem[instrAddr[9:2]];
    assign dataRdData = dmem[dataAddr[9:2]];

    // image copied in during reset and stores captured at the edge
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 256; i++) begin
                dmem[i] <= dataImage[i];
            end
            weCount <= 0;
            reCount <= 0;
        end else begin
            if (dataWe) begin
                dmem[dataAddr[9:2]] <= dataWrData;
                weCount <= weCount + 1;
            end
            if (dataRe) begin
                reCount <= reCount + 1;
            end
        end
    end

    function automatic logic [31:0] fillWord(input int idx);
        logic [7:0] a;
        a = idx[7:0];
        return {a, ~a, a ^ 8'h5A, ~a ^ 8'hC3};
    endfunction

    function automatic logic [31:0] rFormat(input logic [5:0] fn, input int rd,
                                            input int rs, input int rt);
        instrWord w;
        w.r.op = OP_RTYPE;
        w.r.rs = rs[4:0];
        w.r.rt = rt[4:0];
        w.r.rd = rd[4:0];
        w.r.shamt = 5'd0;
        w.r.fn = fn;
        return w;
    endfunction

    function automatic logic [31:0] iFormat(input logic [5:0] op, input int rs,
                                            input int rt, input logic [15:0] imm);
        instrWord w;
        w.i.op = op;
        w.i.rs = rs[4:0];
        w.i.rt = rt[4:0];
        w.i.imm = imm;
        return w;
    endfunction

    function automatic logic [31:0] jFormat(input int target);
        instrWord w;
        w.j.op = OP_J;
        w.j.target = target[25:0];
        return w;
    endfunction

    // signed overflow keeps the old register value when trap is set
    function automatic logic [31:0] addResult(input logic [31:0] a, input logic [31:0] b,
                                              input logic [31:0] old, input bit trap);
        logic [32:0] s;
        logic        ov;
        s = {a[31], a} + {b[31], b};
        // out of range when the two top bits differ
        ov = s[32] != s[31];
        return (trap && ov) ? old : s[31:0];
    endfunction

    function automatic logic [31:0] subResult(input logic [31:0] a, input logic [31:0] b,
                                              input logic [31:0] old, input bit trap);
        logic [32:0] s;
        logic        ov;
        s = {a[31], a} - {b[31], b};
        ov = s[32] != s[31];
        return (trap && ov) ? old : s[31:0];
    endfunction

    function automatic bit branchTaken(input logic [5:0] op, input logic [31:0] a,
                                       input logic [31:0] b);
        case (op)
            OP_BEQ:  return a == b;
            OP_BNE:  return a != b;
            OP_BLEZ: return $signed(a) <= 0;
            OP_BGTZ: return $signed(a) > 0;
            default: return 1'b0;
        endcase
    endfunction

    task automatic setData(input int idx, input logic [31:0] value);
        dataImage[idx] = value;
        expMem[idx] = value;
    endtask

    task automatic expectWord(input int idx, input logic [31:0] value);
        expMem[idx] = value;
    endtask

    task automatic loadWord(input int rt, input int off, input int base);
        prog.push_back(iFormat(OP_LW, base, rt, off[15:0]));
        lwCount++;
    endtask

    task automatic storeWord(input int rt, input int off, input int base);
        prog.push_back(iFormat(OP_SW, base, rt, off[15:0]));
        swCount++;
    endtask

    task automatic regOp(input logic [5:0] fn, input int rd, input int rs, input int rt);
        prog.push_back(rFormat(fn, rd, rs, rt));
    endtask

    task automatic immOp(input logic [5:0] op, input int rt, input int rs,
                         input logic [15:0] imm);
        prog.push_back(iFormat(op, rs, rt, imm));
    endtask

    task automatic selfJump();
        endPc = 4 * prog.size();
        prog.push_back(jFormat(prog.size()));
    endtask

    // branch over one marker store while a second marker store always runs
    task automatic branchOver(input logic [5:0] op, input int rs, input int rt,
                              input logic [31:0] a, input logic [31:0] b,
                              input int slot, input logic [31:0] marker);
        bit takenExp;
        takenExp = branchTaken(op, a, b);
        prog.push_back(iFormat(op, rs, rt, 16'd1));
        storeWord(9, 4 * slot, 0);
        storeWord(9, 4 * (slot + 1), 0);
        if (takenExp) begin
            swCount--;
        end else begin
            expectWord(slot, marker);
        end
        expectWord(slot + 1, marker);
    endtask

    // jr takes its target from r4, which is loaded from word 3
    task automatic jumpOver(input bit viaReg, input int slot, input logic [31:0] marker);
        int idx;
        idx = prog.size();
        if (viaReg) begin
            prog.push_back(rFormat(FN_JR, 0, 4, 0));
            setData(3, 4 * (idx + 2));
        end else begin
            prog.push_back(jFormat(idx + 2));
        end
        storeWord(9, 4 * slot, 0);
        storeWord(9, 4 * (slot + 1), 0);
        swCount--;
        expectWord(slot + 1, marker);
    endtask

    task automatic startTest();
        @(posedge clk);
        #1;
        rst = 1'b1;
        prog.delete();
        swCount = 0;
        lwCount = 0;
        errStart = errors;
        for (int i = 0; i < 256; i++) begin
            imem[i] = 32'd0;
            dataImage[i] = fillWord(i);
            expMem[i] = fillWord(i);
        end
    endtask

    task automatic runProgram();
        for (int i = 0; i < prog.size(); i++) begin
            imem[i] = prog[i];
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (RUN_CYCLES) @(posedge clk);
        #1;
    endtask

    task automatic finishTest(input string name);
        for (int i = 0; i < 256; i++) begin
            assert (dmem[i] === expMem[i]) else begin
                $display("MISMATCH at %0d ns: %s, data word %0d is %h, expected %h",
                         $time, name, i, dmem[i], expMem[i]);
                errors++;
            end
        end
        assert (weCount == swCount) else begin
            $display("MISMATCH at %0d ns: %s, dataWe high in %0d cycles, expected %0d",
                     $time, name, weCount, swCount);
            errors++;
        end
        assert (reCount == lwCount) else begin
            $display("MISMATCH at %0d ns: %s, dataRe high in %0d cycles, expected %0d",
                     $time, name, reCount, lwCount);
            errors++;
        end
        assert (instrAddr === endPc) else begin
            $display("MISMATCH at %0d ns: %s, pc is %h, expected %h",
                     $time, name, instrAddr, endPc);
            errors++;
        end
        testsRun++;
        if (errors == errStart) begin
            $display("test %s: ok", name);
        end else begin
            testsFailed++;
            $display("test %s: %0d errors", name, errors - errStart);
        end
    endtask

    task automatic arithLogicTest();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] pos;
        logic [31:0] neg;
        logic [31:0] keep;
        logic [31:0] rnd;
        startTest();
        a = $urandom;
        b = $urandom;
        rnd = $urandom;
        pos = {2'b01, rnd[29:0]};
        rnd = $urandom;
        neg = {2'b10, rnd[29:0]};
        keep = $urandom;
        setData(0, a);
        setData(1, b);
        setData(2, pos);
        setData(3, neg);
        setData(4, keep);
        loadWord(1, 0, 0);
        loadWord(2, 4, 0);
        loadWord(3, 8, 0);
        loadWord(4, 12, 0);
        loadWord(13, 16, 0);
        loadWord(14, 16, 0);
        regOp(FN_ADD, 5, 1, 2);
        regOp(FN_ADDU, 6, 1, 2);
        regOp(FN_SUB, 7, 1, 2);
        regOp(FN_SUBU, 8, 1, 2);
        regOp(FN_AND, 9, 1, 2);
        regOp(FN_OR, 10, 1, 2);
        regOp(FN_XOR, 11, 1, 2);
        regOp(FN_NOR, 12, 1, 2);
        // forced overflow into registers holding keep
        regOp(FN_ADD, 13, 3, 3);
        regOp(FN_SUB, 14, 3, 4);
        regOp(FN_ADDU, 15, 3, 3);
        regOp(FN_SUBU, 16, 3, 4);
        for (int r = 5; r <= 16; r++) begin
            storeWord(r, 4 * (64 + r - 5), 0);
        end
        selfJump();
        expectWord(64, addResult(a, b, 32'd0, 1'b1));
        expectWord(65, addResult(a, b, 32'd0, 1'b0));
        expectWord(66, subResult(a, b, 32'd0, 1'b1));
        expectWord(67, subResult(a, b, 32'd0, 1'b0));
        expectWord(68, a & b);
        expectWord(69, a | b);
        expectWord(70, a ^ b);
        expectWord(71, ~(a | b));
        expectWord(72, addResult(pos, pos, keep, 1'b1));
        expectWord(73, subResult(pos, neg, keep, 1'b1));
        expectWord(74, addResult(pos, pos, keep, 1'b0));
        expectWord(75, subResult(pos, neg, keep, 1'b0));
        runProgram();
        finishTest("register arithmetic");
    endtask

    task automatic immediateTest();
        logic [31:0] a;
        logic [31:0] rnd;
        logic [15:0] imm [0:4];
        startTest();
        a = $urandom;
        // bit 15 set everywhere so sign and zero extension differ
        for (int i = 0; i < 5; i++) begin
            rnd = $urandom;
            imm[i] = 16'h8000 | rnd[15:0];
        end
        setData(0, a);
        loadWord(1, 0, 0);
        immOp(OP_ADDI, 2, 1, imm[0]);
        immOp(OP_ADDIU, 3, 1, imm[1]);
        immOp(OP_ANDI, 4, 1, imm[2]);
        immOp(OP_ORI, 5, 1, imm[3]);
        immOp(OP_XORI, 6, 1, imm[4]);
        immOp(OP_ADDIU, 7, 0, imm[1]);
        immOp(OP_ADDI, 0, 1, imm[0]);
        immOp(OP_ORI, 0, 1, imm[3]);
        for (int r = 2; r <= 7; r++) begin
            storeWord(r, 4 * (62 + r), 0);
        end
        storeWord(0, 4 * 70, 0);
        selfJump();
        expectWord(64, addResult(a, {{16{imm[0][15]}}, imm[0]}, 32'd0, 1'b1));
        expectWord(65, a + {{16{imm[1][15]}}, imm[1]});
        expectWord(66, a & {16'd0, imm[2]});
        expectWord(67, a | {16'd0, imm[3]});
        expectWord(68, a ^ {16'd0, imm[4]});
        expectWord(69, {{16{imm[1][15]}}, imm[1]});
        expectWord(70, 32'd0);
        runProgram();
        finishTest("immediates");
    endtask

    task automatic shiftTest();
        logic [31:0] v1;
        logic [31:0] v2;
        logic [31:0] amt;
        logic [31:0] rnd;
        logic [31:0] sra1;
        logic [31:0] sra2;
        logic [4:0]  sh;
        startTest();
        v1 = $urandom | 32'h8000_0000;
        v2 = $urandom & 32'h7FFF_FFFF;
        rnd = $urandom;
        sh = rnd[4:0];
        if (sh == 5'd0) begin
            sh = 5'd13;
        end
        // upper bits of the amount are noise
        amt = {rnd[31:5], sh};
        setData(0, v1);
        setData(1, amt);
        setData(2, v2);
        loadWord(1, 0, 0);
        loadWord(2, 4, 0);
        loadWord(3, 8, 0);
        regOp(FN_SLLV, 4, 2, 1);
        regOp(FN_SRLV, 5, 2, 1);
        regOp(FN_SRAV, 6, 2, 1);
        regOp(FN_SRAV, 7, 2, 3);
        for (int r = 4; r <= 7; r++) begin
            storeWord(r, 4 * (60 + r), 0);
        end
        selfJump();
        sra1 = $signed(v1) >>> sh;
        sra2 = $signed(v2) >>> sh;
        expectWord(64, v1 << sh);
        expectWord(65, v1 >> sh);
        expectWord(66, sra1);
        expectWord(67, sra2);
        runProgram();
        finishTest("variable shifts");
    endtask

    task automatic memoryTest();
        logic [31:0] value;
        int          off;
        int          storeOff;
        int          srcIdx;
        int          dstIdx;
        int          k;
        startTest();
        value = $urandom;
        k = $urandom_range(15, 0);
        off = -4 * (1 + k);
        k = $urandom_range(7, 0);
        storeOff = 4 * (1 + k);
        // base address 0x200 sits at word 128
        srcIdx = (512 + off) / 4;
        dstIdx = (512 + storeOff) / 4;
        setData(0, 32'h0000_0200);
        setData(srcIdx, value);
        loadWord(1, 0, 0);
        loadWord(2, off, 1);
        storeWord(2, storeOff, 1);
        storeWord(2, 256, 0);
        selfJump();
        expectWord(dstIdx, value);
        expectWord(64, value);
        runProgram();
        finishTest("memory");
    endtask

    task automatic controlFlowTest();
        logic [31:0] pos;
        logic [31:0] neg;
        logic [31:0] marker;
        logic [31:0] rnd;
        startTest();
        rnd = $urandom;
        pos = {1'b0, rnd[30:1], 1'b1};
        neg = $urandom | 32'h8000_0000;
        marker = $urandom;
        setData(0, pos);
        setData(1, neg);
        setData(2, marker);
        loadWord(1, 0, 0);
        loadWord(2, 4, 0);
        loadWord(9, 8, 0);
        loadWord(3, 0, 0);
        loadWord(4, 12, 0);
        branchOver(OP_BEQ, 1, 3, pos, pos, 64, marker);
        branchOver(OP_BEQ, 1, 2, pos, neg, 66, marker);
        branchOver(OP_BNE, 1, 2, pos, neg, 68, marker);
        branchOver(OP_BNE, 1, 3, pos, pos, 70, marker);
        branchOver(OP_BLEZ, 2, 0, neg, 32'd0, 72, marker);
        branchOver(OP_BLEZ, 1, 0, pos, 32'd0, 74, marker);
        branchOver(OP_BLEZ, 0, 0, 32'd0, 32'd0, 76, marker);
        branchOver(OP_BGTZ, 1, 0, pos, 32'd0, 78, marker);
        branchOver(OP_BGTZ, 2, 0, neg, 32'd0, 80, marker);
        branchOver(OP_BGTZ, 0, 0, 32'd0, 32'd0, 82, marker);
        jumpOver(1'b0, 84, marker);
        jumpOver(1'b1, 86, marker);
        selfJump();
        runProgram();
        finishTest("control flow");
    endtask

    task automatic unknownOpTest();
        logic [31:0] value;
        logic [31:0] rnd;
        startTest();
        value = $urandom;
        rnd = $urandom;
        setData(0, value);
        loadWord(1, 0, 0);
        // encodings outside the subset aimed at r1 or memory
        prog.push_back(iFormat(6'd63, 1, 1, rnd[15:0]));
        prog.push_back(rFormat(6'b000000, 1, 1, 1));
        prog.push_back(iFormat(6'b001111, 0, 1, rnd[31:16]));
        prog.push_back(iFormat(6'b100000, 0, 1, 16'd0));
        prog.push_back(iFormat(6'b101000, 0, 1, 16'd264));
        prog.push_back(rFormat(6'b101010, 1, 1, 0));
        prog.push_back(iFormat(6'b000011, 0, 0, 16'd0));
        storeWord(1, 256, 0);
        selfJump();
        expectWord(64, value);
        runProgram();
        finishTest("unknown encodings");
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Verification failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h7345));
        rst = 1'b1;
        errors = 0;
        testsRun = 0;
        testsFailed = 0;
        lwCount = 0;
        endPc = 32'd0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = 32'd0;
            dataImage[i] = fillWord(i);
            expMem[i] = fillWord(i);
        end
        arithLogicTest();
        immediateTest();
        shiftTest();
        memoryTest();
        controlFlowTest();
        unknownOpTest();
        $display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 testsRun, testsRun - testsFailed, testsFailed, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
logic/mipsPkg.sv
logic/control.sv
logic/regFile.sv
logic/alu.sv
logic/branchCompare.sv
logic/cpuCore.sv
verif/cpuCoreTb.sv

// File: run.sh
#!/bin/sh
# Build and run the cpuCore testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f vlog.f --top-module cpuCoreTb -Mdir obj_dir -o cpuCoreSim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/cpuCoreSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Verification failed" sim.log; then
    exit 1
fi
if ! grep -q "Verification passed" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0
